// ==== hdl/bpred_pkg.sv ====
// branch prediction types for lookup results and execute-stage training
// addresses here are 40 bits, matching the fetch address width
// no dependency on the fetch package, so this one compiles first
package bpred_pkg;

    typedef enum logic {
        PRED_NOT_TAKEN = 1'b0,
        PRED_TAKEN     = 1'b1
    } pred_decision_t;

    // lookup result, travels with the instruction down the pipe
    typedef struct packed {
        logic           is_branch;
        pred_decision_t decision;
        logic [39:0]    pred_addr;
    } bpred_t;

    // resolved branch coming back from execute
    // is_branch qualifies the whole update
    typedef struct packed {
        logic        is_branch;
        logic        taken;
        logic [39:0] pc_execution;
        logic [39:0] target;
    } exe_update_t;

endpackage

// ==== hdl/fetch_pkg.sv ====
// fetch stage types shared by the PC generator, the output stage and the top level
// addresses are 40 bits wide and no 64-bit PC is carried anywhere
// the memory map below is fixed and only used when translation is off
package fetch_pkg;

    // instruction address, sized to what the icache request carries
    typedef logic [39:0] addr_t;

    // next-PC source chosen by the control unit
    typedef enum logic [1:0] {
        NEXT_PC_SEL_KEEP_PC    = 2'd0,
        NEXT_PC_SEL_BP_OR_PC_4 = 2'd1,
        NEXT_PC_SEL_JUMP       = 2'd2,
        NEXT_PC_SEL_DEBUG      = 2'd3
    } next_pc_sel_t;

    // only the two fetch-side causes are needed here
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        INSTR_ACCESS_FAULT    = 4'd1
    } exc_cause_t;

    typedef struct packed {
        logic       valid;
        exc_cause_t cause;
        addr_t      origin;
    } exception_t;

    // request towards the instruction cache
    typedef struct packed {
        logic  valid;
        addr_t vaddr;
        logic  invalidate_icache;
        logic  invalidate_buffer;
        logic  inval_fetch;
    } icache_req_t;

    // packet handed to the second fetch stage
    typedef struct packed {
        logic              valid;
        addr_t             pc_inst;
        exception_t        ex;
        bpred_pkg::bpred_t bpred;
    } fetch_packet_t;

    // fixed SoC map for the untranslated fault check
    // the unmapped window is [lower, upper), everything from the limit upwards faults
    localparam addr_t UNMAPPED_LOWER = 40'h00_0000_0100;
    localparam addr_t UNMAPPED_UPPER = 40'h00_0000_1000;
    localparam addr_t PHYS_MEM_LIMIT = 40'h00_8000_0000;

endpackage

// ==== hdl/pc_gen.sv ====
// program counter register and next-PC selection
// the PC loads on every edge; stalls do not freeze it, the control unit
// must select keep while it stalls
`timescale 1ns/1ps

module pc_gen #(
    parameter fetch_pkg::addr_t RESET_ADDR = 40'h00_8000_0000 - 40'h00_0001_0000
) (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  fetch_pkg::next_pc_sel_t next_pc_sel_i,
    input  fetch_pkg::addr_t        pc_jump_i,
    input  bpred_pkg::bpred_t       pred_i,
    output fetch_pkg::addr_t        pc_o
);

    fetch_pkg::addr_t pc_q;
    fetch_pkg::addr_t pc_plus_4;
    fetch_pkg::addr_t next_pc;
    logic             follow_pred;

    assign pc_plus_4 = pc_q + 40'd4;

    // predictor only redirects on a known branch predicted taken
    assign follow_pred = pred_i.is_branch && (pred_i.decision == bpred_pkg::PRED_TAKEN);

    always_comb begin
        case (next_pc_sel_i)
            fetch_pkg::NEXT_PC_SEL_KEEP_PC: begin
                next_pc = pc_q;
            end
            fetch_pkg::NEXT_PC_SEL_BP_OR_PC_4: begin
                if (follow_pred) begin
                    next_pc = pred_i.pred_addr;
                end else begin
                    next_pc = pc_plus_4;
                end
            end
            // debug redirect shares the jump address path
            fetch_pkg::NEXT_PC_SEL_JUMP,
            fetch_pkg::NEXT_PC_SEL_DEBUG: begin
                next_pc = pc_jump_i;
            end
            default: begin
                // undefined select, just keep fetching sequentially
                next_pc = pc_plus_4;
            end
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q <= RESET_ADDR;
        end else begin
            pc_q <= next_pc;
        end
    end

    assign pc_o = pc_q;

    // the control unit must always drive a defined select once out of reset
    a_sel_known: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !$isunknown(next_pc_sel_i)
    ) else $error("pc_gen: next_pc_sel_i is unknown");

endmodule

// ==== hdl/branch_predictor.sv ====
// two-bit counter table plus a tagged target buffer, direct mapped
// lookup is combinational; training is written at the edge with no bypass,
// so a lookup in the update cycle still sees the old entry
`timescale 1ns/1ps

module branch_predictor #(
    parameter int unsigned BHT_INDEX_BITS = 6
) (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  fetch_pkg::addr_t       pc_fetch_i,
    input  bpred_pkg::exe_update_t exe_update_i,
    output bpred_pkg::bpred_t      pred_o
);

    localparam int unsigned ENTRIES  = 1 << BHT_INDEX_BITS;
    localparam int unsigned TAG_LSB  = BHT_INDEX_BITS + 2;
    localparam int unsigned TAG_BITS = 40 - TAG_LSB;

    // tag and target of one target buffer line
    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        fetch_pkg::addr_t    target;
    } btb_entry_t;

    logic [1:0]          counter_q [ENTRIES];
    logic [ENTRIES-1:0]  btb_valid_q;
    btb_entry_t          btb_q [ENTRIES];

    logic [BHT_INDEX_BITS-1:0] fetch_idx;
    logic [TAG_BITS-1:0]       fetch_tag;
    logic                      hit;

    logic [BHT_INDEX_BITS-1:0] upd_idx;
    logic [1:0]                upd_counter;
    logic [1:0]                counter_next;

    // lookup
    assign fetch_idx = pc_fetch_i[BHT_INDEX_BITS+1:2];
    assign fetch_tag = pc_fetch_i[39:TAG_LSB];

    assign hit = btb_valid_q[fetch_idx] && (btb_q[fetch_idx].tag == fetch_tag);

    assign pred_o.is_branch = hit;
    // upper counter bit set means weakly or strongly taken
    assign pred_o.decision  = (hit && counter_q[fetch_idx][1]) ? bpred_pkg::PRED_TAKEN
                                                                : bpred_pkg::PRED_NOT_TAKEN;
    assign pred_o.pred_addr = btb_q[fetch_idx].target;

    // training
    assign upd_idx     = exe_update_i.pc_execution[BHT_INDEX_BITS+1:2];
    assign upd_counter = counter_q[upd_idx];

    // saturating step towards the resolved direction
    always_comb begin
        counter_next = upd_counter;
        if (exe_update_i.taken) begin
            if (upd_counter != 2'b11) begin
                counter_next = upd_counter + 2'd1;
            end
        end else if (upd_counter != 2'b00) begin
            counter_next = upd_counter - 2'd1;
        end
    end

    // counters start weakly not taken, buffer lines start empty
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < ENTRIES; i++) begin
                counter_q[i] <= 2'b01;
            end
            btb_valid_q <= '0;
        end else if (exe_update_i.is_branch) begin
            counter_q[upd_idx]   <= counter_next;
            btb_valid_q[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (exe_update_i.is_branch) begin
            btb_q[upd_idx].tag    <= exe_update_i.pc_execution[39:TAG_LSB];
            btb_q[upd_idx].target <= exe_update_i.target;
        end
    end

    // execute only trains on aligned instruction addresses, otherwise the
    // index bits would alias a different fetch word
    a_upd_aligned: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        exe_update_i.is_branch |-> (exe_update_i.pc_execution[1:0] == 2'b00)
    ) else $error("branch_predictor: misaligned update pc");

endmodule

// ==== hdl/fetch_out.sv ====
// exception checks on the current PC and the registered fetch outputs
// everything from PC n leaves one cycle later with that cycle's stall and
// invalidate inputs; there is no queue, a stalled output is simply dropped
`timescale 1ns/1ps

module fetch_out (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  fetch_pkg::addr_t         pc_i,
    input  bpred_pkg::bpred_t        pred_i,
    input  logic                     stall_i,
    input  logic                     stall_debug_i,
    input  logic                     en_translation_i,
    input  logic                     invalidate_icache_i,
    input  logic                     invalidate_buffer_i,
    input  logic                     retry_fetch_i,
    output fetch_pkg::icache_req_t   icache_req_o,
    output fetch_pkg::fetch_packet_t fetch_o
);

    logic                  misaligned;
    logic                  access_fault;
    logic                  stalled;
    fetch_pkg::exception_t ex_d;

    // control registers
    logic fetch_valid_q;
    logic req_valid_q;
    logic inval_icache_q;
    logic inval_buffer_q;
    logic inval_fetch_q;

    // payload registers
    fetch_pkg::addr_t      pc_q;
    fetch_pkg::exception_t ex_q;
    bpred_pkg::bpred_t     pred_q;

    assign misaligned = |pc_i[1:0];

    // with translation the address must be sign extended from bit 38
    always_comb begin
        if (en_translation_i) begin
            access_fault = pc_i[39] ^ pc_i[38];
        end else begin
            access_fault = ((pc_i >= fetch_pkg::UNMAPPED_LOWER) &&
                            (pc_i <  fetch_pkg::UNMAPPED_UPPER)) ||
                           (pc_i >= fetch_pkg::PHYS_MEM_LIMIT);
        end
    end

    // misalignment takes priority over the fault
    always_comb begin
        ex_d.origin = pc_i;
        if (misaligned) begin
            ex_d.valid = 1'b1;
            ex_d.cause = fetch_pkg::INSTR_ADDR_MISALIGNED;
        end else if (access_fault) begin
            ex_d.valid = 1'b1;
            ex_d.cause = fetch_pkg::INSTR_ACCESS_FAULT;
        end else begin
            ex_d.valid = 1'b0;
            ex_d.cause = fetch_pkg::exc_cause_t'(4'd0);
        end
    end

    assign stalled = stall_i || stall_debug_i;

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            fetch_valid_q  <= 1'b0;
            req_valid_q    <= 1'b0;
            inval_icache_q <= 1'b0;
            inval_buffer_q <= 1'b0;
            inval_fetch_q  <= 1'b0;
        end else begin
            fetch_valid_q  <= !stalled;
            // no cache access for an address that already raised an exception
            req_valid_q    <= !stalled && !ex_d.valid;
            inval_icache_q <= invalidate_icache_i;
            inval_buffer_q <= invalidate_buffer_i || retry_fetch_i;
            inval_fetch_q  <= retry_fetch_i;
        end
    end

    always_ff @(posedge clk_i) begin
        pc_q   <= pc_i;
        ex_q   <= ex_d;
        pred_q <= pred_i;
    end

    assign icache_req_o.valid             = req_valid_q;
    assign icache_req_o.vaddr             = pc_q;
    assign icache_req_o.invalidate_icache = inval_icache_q;
    assign icache_req_o.invalidate_buffer = inval_buffer_q;
    assign icache_req_o.inval_fetch       = inval_fetch_q;

    assign fetch_o.valid   = fetch_valid_q;
    assign fetch_o.pc_inst = pc_q;
    assign fetch_o.ex      = ex_q;
    assign fetch_o.bpred   = pred_q;

    // a faulting fetch must never reach the cache
    a_no_req_on_ex: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        icache_req_o.valid |-> !fetch_o.ex.valid
    ) else $error("fetch_out: icache request issued with a pending exception");

endmodule

// ==== hdl/fetch_front_end.sv ====
// first fetch stage: PC generation, branch lookup and registered outputs
// one cycle from PC to icache_req_o and fetch_o; no handshake on either
`timescale 1ns/1ps

module fetch_front_end #(
    parameter fetch_pkg::addr_t RESET_ADDR     = 40'h00_8000_0000 - 40'h00_0001_0000,
    parameter int unsigned      BHT_INDEX_BITS = 6
) (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  fetch_pkg::next_pc_sel_t  next_pc_sel_i,
    input  fetch_pkg::addr_t         pc_jump_i,
    input  logic                     stall_i,
    input  logic                     stall_debug_i,
    input  logic                     en_translation_i,
    input  logic                     invalidate_icache_i,
    input  logic                     invalidate_buffer_i,
    input  logic                     retry_fetch_i,
    input  bpred_pkg::exe_update_t   exe_update_i,
    output fetch_pkg::icache_req_t   icache_req_o,
    output fetch_pkg::fetch_packet_t fetch_o
);

    fetch_pkg::addr_t  pc;
    bpred_pkg::bpred_t pred;

    pc_gen #(
        .RESET_ADDR (RESET_ADDR)
    ) u_pc_gen (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .next_pc_sel_i (next_pc_sel_i),
        .pc_jump_i     (pc_jump_i),
        .pred_i        (pred),
        .pc_o          (pc)
    );

    // lookup is combinational on the current PC
    branch_predictor #(
        .BHT_INDEX_BITS (BHT_INDEX_BITS)
    ) u_branch_predictor (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .pc_fetch_i   (pc),
        .exe_update_i (exe_update_i),
        .pred_o       (pred)
    );

    fetch_out u_fetch_out (
        .clk_i               (clk_i),
        .rstn_i              (rstn_i),
        .pc_i                (pc),
        .pred_i              (pred),
        .stall_i             (stall_i),
        .stall_debug_i       (stall_debug_i),
        .en_translation_i    (en_translation_i),
        .invalidate_icache_i (invalidate_icache_i),
        .invalidate_buffer_i (invalidate_buffer_i),
        .retry_fetch_i       (retry_fetch_i),
        .icache_req_o        (icache_req_o),
        .fetch_o             (fetch_o)
    );

endmodule

// ==== verif/fetch_tb.sv ====
// random testbench for the fetch front end, checked against a cycle model
// stimulus from $random with a fixed seed; pred_addr is only compared on a hit
// since target buffer lines start without a reset value
`timescale 1ns/1ps

module fetch_tb;

    localparam fetch_pkg::addr_t RESET_ADDR     = 40'h00_7fff_0000;
    localparam int unsigned      BHT_INDEX_BITS = 6;
    localparam int unsigned      ENTRIES        = 1 << BHT_INDEX_BITS;
    localparam int unsigned      TAG_LSB        = BHT_INDEX_BITS + 2;
    localparam int               RESET_CYCLES   = 4;
    localparam int               NUM_CYCLES     = 1500;
    localparam time              TIMEOUT_NS     = (NUM_CYCLES + RESET_CYCLES) * 40 * 2;

    logic                     clk_i;
    logic                     rstn_i;
    fetch_pkg::next_pc_sel_t  next_pc_sel_i;
    fetch_pkg::addr_t         pc_jump_i;
    logic                     stall_i;
    logic                     stall_debug_i;
    logic                     en_translation_i;
    logic                     invalidate_icache_i;
    logic                     invalidate_buffer_i;
    logic                     retry_fetch_i;
    bpred_pkg::exe_update_t   exe_update_i;
    fetch_pkg::icache_req_t   icache_req_o;
    fetch_pkg::fetch_packet_t fetch_o;

    integer seed;
    int     cycle;
    int     mismatch_cnt;
    int     other_cnt;
    int     taken_seen;
    int     misaligned_seen;
    int     fault_seen;

    // jump targets: aligned code, misaligned, unmapped window, above the limit
    fetch_pkg::addr_t jump_set [8] = '{40'h00_0000_2000, 40'h00_0000_2040, 40'h00_0000_3080,
        RESET_ADDR, 40'h00_0000_2002, 40'h00_0000_0101, 40'h00_0000_0200, 40'h40_0000_0000};
    fetch_pkg::addr_t branch_pc [4] = '{40'h00_0000_2000, 40'h00_0000_2040, 40'h00_0000_3080,
        40'h00_7fff_0040};
    fetch_pkg::addr_t branch_tgt [4] = '{40'h00_0000_3080, 40'h00_0000_2100, 40'h00_0000_2000,
        RESET_ADDR};

    // reference model state
    fetch_pkg::addr_t         m_pc;
    logic [1:0]               m_cnt [ENTRIES];
    logic                     m_valid [ENTRIES];
    logic [39-TAG_LSB:0]      m_tag [ENTRIES];
    fetch_pkg::addr_t         m_tgt [ENTRIES];
    fetch_pkg::fetch_packet_t exp_fetch;
    fetch_pkg::icache_req_t   exp_req;

    fetch_front_end #(
        .RESET_ADDR     (RESET_ADDR),
        .BHT_INDEX_BITS (BHT_INDEX_BITS)
    ) u_fetch_front_end (
        .clk_i               (clk_i),
        .rstn_i              (rstn_i),
        .next_pc_sel_i       (next_pc_sel_i),
        .pc_jump_i           (pc_jump_i),
        .stall_i             (stall_i),
        .stall_debug_i       (stall_debug_i),
        .en_translation_i    (en_translation_i),
        .invalidate_icache_i (invalidate_icache_i),
        .invalidate_buffer_i (invalidate_buffer_i),
        .retry_fetch_i       (retry_fetch_i),
        .exe_update_i        (exe_update_i),
        .icache_req_o        (icache_req_o),
        .fetch_o             (fetch_o)
    );

    always #20 clk_i = ~clk_i;

    task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        $display("mismatch %s at cycle %0d: expected %h, actual %h", name, cycle, exp_v, act_v);
        mismatch_cnt++;
    endtask

    task automatic check_fetch(input fetch_pkg::fetch_packet_t exp_p,
                               input fetch_pkg::fetch_packet_t act_p);
        if (act_p.valid !== exp_p.valid)
            report_mismatch("fetch_o.valid", 64'(exp_p.valid), 64'(act_p.valid));
        if (act_p.pc_inst !== exp_p.pc_inst)
            report_mismatch("fetch_o.pc_inst", 64'(exp_p.pc_inst), 64'(act_p.pc_inst));
        if (act_p.ex.valid !== exp_p.ex.valid)
            report_mismatch("fetch_o.ex.valid", 64'(exp_p.ex.valid), 64'(act_p.ex.valid));
        if (act_p.ex.cause !== exp_p.ex.cause)
            report_mismatch("fetch_o.ex.cause", 64'(exp_p.ex.cause), 64'(act_p.ex.cause));
        if (act_p.ex.origin !== exp_p.ex.origin)
            report_mismatch("fetch_o.ex.origin", 64'(exp_p.ex.origin), 64'(act_p.ex.origin));
        if (act_p.bpred.is_branch !== exp_p.bpred.is_branch)
            report_mismatch("fetch_o.bpred.is_branch", 64'(exp_p.bpred.is_branch),
                            64'(act_p.bpred.is_branch));
        if (act_p.bpred.decision !== exp_p.bpred.decision)
            report_mismatch("fetch_o.bpred.decision", 64'(exp_p.bpred.decision),
                            64'(act_p.bpred.decision));
        if (exp_p.bpred.is_branch && (act_p.bpred.pred_addr !== exp_p.bpred.pred_addr))
            report_mismatch("fetch_o.bpred.pred_addr", 64'(exp_p.bpred.pred_addr),
                            64'(act_p.bpred.pred_addr));
    endtask

    task automatic check_icache_req(input fetch_pkg::icache_req_t exp_r,
                                    input fetch_pkg::icache_req_t act_r);
        if (act_r !== exp_r)
            report_mismatch("icache_req_o", 64'(exp_r), 64'(act_r));
    endtask

    // one clock edge of the reference model, using the inputs held before it
    task automatic model_edge(input logic in_reset);
        logic [BHT_INDEX_BITS-1:0] idx;
        logic [BHT_INDEX_BITS-1:0] uidx;
        logic                      hit;
        logic                      pred_taken;
        logic                      mis;
        logic                      flt;
        logic                      stalled;
        idx = m_pc[TAG_LSB-1:2];
        hit = m_valid[idx] && (m_tag[idx] == m_pc[39:TAG_LSB]);
        pred_taken = hit && (m_cnt[idx] >= 2'd2);
        mis = (m_pc[1:0] != 2'b00);
        if (en_translation_i)
            flt = (m_pc[39] != m_pc[38]);
        else
            flt = ((m_pc >= fetch_pkg::UNMAPPED_LOWER) && (m_pc < fetch_pkg::UNMAPPED_UPPER)) ||
                  (m_pc >= fetch_pkg::PHYS_MEM_LIMIT);
        stalled = stall_i || stall_debug_i;

        exp_fetch.valid           = !in_reset && !stalled;
        exp_fetch.pc_inst         = m_pc;
        exp_fetch.ex.valid        = mis || flt;
        exp_fetch.ex.cause        = (!mis && flt) ? fetch_pkg::INSTR_ACCESS_FAULT
                                                  : fetch_pkg::INSTR_ADDR_MISALIGNED;
        exp_fetch.ex.origin       = m_pc;
        exp_fetch.bpred.is_branch = hit;
        exp_fetch.bpred.decision  = pred_taken ? bpred_pkg::PRED_TAKEN
                                               : bpred_pkg::PRED_NOT_TAKEN;
        exp_fetch.bpred.pred_addr = m_tgt[idx];
        exp_req.valid             = !in_reset && !stalled && !(mis || flt);
        exp_req.vaddr             = m_pc;
        exp_req.invalidate_icache = !in_reset && invalidate_icache_i;
        exp_req.invalidate_buffer = !in_reset && (invalidate_buffer_i || retry_fetch_i);
        exp_req.inval_fetch       = !in_reset && retry_fetch_i;

        if (in_reset) begin
            m_pc = RESET_ADDR;
            for (int i = 0; i < ENTRIES; i++) begin
                m_cnt[i]   = 2'b01;
                m_valid[i] = 1'b0;
                m_tgt[i]   = '0;
            end
        end else begin
            if (exp_fetch.valid && pred_taken)
                taken_seen++;
            if (mis)
                misaligned_seen++;
            else if (flt)
                fault_seen++;
            case (next_pc_sel_i)
                fetch_pkg::NEXT_PC_SEL_KEEP_PC: m_pc = m_pc;
                fetch_pkg::NEXT_PC_SEL_BP_OR_PC_4: m_pc = pred_taken ? m_tgt[idx] : m_pc + 40'd4;
                default: m_pc = pc_jump_i;
            endcase
            if (exe_update_i.is_branch) begin
                uidx = exe_update_i.pc_execution[TAG_LSB-1:2];
                if (exe_update_i.taken && (m_cnt[uidx] != 2'd3))
                    m_cnt[uidx] = m_cnt[uidx] + 2'd1;
                else if (!exe_update_i.taken && (m_cnt[uidx] != 2'd0))
                    m_cnt[uidx] = m_cnt[uidx] - 2'd1;
                m_valid[uidx] = 1'b1;
                m_tag[uidx]   = exe_update_i.pc_execution[39:TAG_LSB];
                m_tgt[uidx]   = exe_update_i.target;
            end
        end
    endtask

    // mostly sequential fetch; updates lean taken first and not taken later
    task automatic drive_inputs();
        logic [31:0]            r;
        logic [31:0]            u;
        bpred_pkg::exe_update_t upd;
        r = $random(seed);
        u = $random(seed);
        if (r[3:0] < 4'd10)
            next_pc_sel_i <= fetch_pkg::NEXT_PC_SEL_BP_OR_PC_4;
        else if (r[3:0] < 4'd12)
            next_pc_sel_i <= fetch_pkg::NEXT_PC_SEL_KEEP_PC;
        else if (r[3:0] == 4'd14)
            next_pc_sel_i <= fetch_pkg::NEXT_PC_SEL_DEBUG;
        else
            next_pc_sel_i <= fetch_pkg::NEXT_PC_SEL_JUMP;
        pc_jump_i           <= jump_set[r[6:4]];
        stall_i             <= (r[9:7] == 3'd0);
        stall_debug_i       <= (r[13:10] == 4'd0);
        en_translation_i    <= (r[15:14] == 2'd0);
        invalidate_icache_i <= (r[19:16] == 4'd0);
        invalidate_buffer_i <= (r[23:20] == 4'd0);
        retry_fetch_i       <= (r[27:24] == 4'd0);
        upd.is_branch    = (u[1:0] == 2'd0);
        upd.taken        = (cycle < NUM_CYCLES / 2) ? (u[5:4] != 2'd0) : (u[5:4] == 2'd0);
        upd.pc_execution = branch_pc[u[3:2]];
        upd.target       = branch_tgt[u[3:2]];
        exe_update_i <= upd;
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the test did not finish within %0t", TIMEOUT_NS);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        seed                = 32'hcde1;
        mismatch_cnt        = 0;
        other_cnt           = 0;
        taken_seen          = 0;
        misaligned_seen     = 0;
        fault_seen          = 0;
        clk_i               = 1'b0;
        rstn_i              = 1'b0;
        next_pc_sel_i       = fetch_pkg::NEXT_PC_SEL_BP_OR_PC_4;
        pc_jump_i           = '0;
        stall_i             = 1'b0;
        stall_debug_i       = 1'b0;
        en_translation_i    = 1'b0;
        invalidate_icache_i = 1'b0;
        invalidate_buffer_i = 1'b0;
        retry_fetch_i       = 1'b0;
        exe_update_i        = '0;
        m_pc                = RESET_ADDR;

        for (cycle = 0; cycle < RESET_CYCLES + NUM_CYCLES; cycle++) begin
            @(posedge clk_i);
            model_edge(!rstn_i);
            if (cycle == RESET_CYCLES - 1)
                rstn_i <= 1'b1;
            if (cycle >= RESET_CYCLES - 1)
                drive_inputs();
            // outputs settle well before the falling edge
            @(negedge clk_i);
            // the first edge still registers the PC from before reset
            if (cycle > 0) begin
                check_fetch(exp_fetch, fetch_o);
                check_icache_req(exp_req, icache_req_o);
            end
        end

        if (taken_seen == 0) begin
            $display("no fetch with a taken prediction was seen");
            other_cnt++;
        end
        if ((misaligned_seen == 0) || (fault_seen == 0)) begin
            $display("misaligned or faulting fetches were never seen");
            other_cnt++;
        end
        $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
        if ((mismatch_cnt == 0) && (other_cnt == 0))
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== files.f ====
hdl/bpred_pkg.sv
hdl/fetch_pkg.sv
hdl/pc_gen.sv
hdl/branch_predictor.sv
hdl/fetch_out.sv
hdl/fetch_front_end.sv
verif/fetch_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fetch front end testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f files.f --top-module fetch_tb -Mdir "$BUILD_DIR" -o fetch_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/fetch_tb_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
    echo "simulation log has no result line"
    exit 1
fi
exit 0
